// File: hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ====================
// Address map and sizes
// ====================

// Dword address of the first CSR in the MMIO window
`define CSR_BASE_ADDR 16'h0100
// 64-bit store entries, two dwords each
`define CSR_NUM_ENTRIES 16
`define CSR_WINDOW_DWORDS (2 * `CSR_NUM_ENTRIES)
`define CSR_NUM_STATS 6
// Accumulators are folded into the store every 2**N cycles
`define STAT_FLUSH_PERIOD_LOG2 10
`define REQ_FIFO_DEPTH 64

// ====================
// Feature headers and IDs
// ====================

// Feature 0, translation. Type 2, next header 64 bytes on
`define CSR_F0_DFH_IDX 4'd0
`define CSR_F0_DFH_VAL 64'h2000_0000_0040_0000
`define CSR_F0_ID_L_IDX 4'd1
`define CSR_F0_ID_L_VAL 64'ha813_5c2e_9f70_d146
`define CSR_F0_ID_H_IDX 4'd2
`define CSR_F0_ID_H_VAL 64'h3a5e_91c4_07d2_4b6f

// Feature 1, channel mapping. Type 2, end of the list
`define CSR_F1_DFH_IDX 4'd8
`define CSR_F1_DFH_VAL 64'h2000_0100_0000_0000
`define CSR_F1_ID_L_IDX 4'd9
`define CSR_F1_ID_L_VAL 64'hc46d_0e8b_2f95_7a31
`define CSR_F1_ID_H_IDX 4'd10
`define CSR_F1_ID_H_VAL 64'h7b20_e6f3_58a9_41dc

// Store entry of each statistic
`define CSR_STAT0_IDX 4'd3
`define CSR_STAT1_IDX 4'd4
`define CSR_STAT2_IDX 4'd5
`define CSR_STAT3_IDX 4'd6
`define CSR_STAT4_IDX 4'd7
`define CSR_STAT5_IDX 4'd11

`endif

// File: hw/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    // Store entry index, one per 64-bit CSR
    typedef logic [3:0] csr_idx_t;
    // MMIO dword address and request tag
    typedef logic [15:0] mmio_addr_t;
    typedef logic [8:0] tid_t;
    typedef logic [63:0] csr_word_t;

    // Small per-event accumulator
    typedef logic [15:0] stat_cnt_t;
    // Element 0 sits in the low bits and is folded first
    typedef csr_idx_t [`CSR_NUM_STATS-1:0] stat_idx_vec_t;
    typedef stat_cnt_t [`CSR_NUM_STATS-1:0] stat_cnt_vec_t;

    // Statistics fold FSM
    typedef enum logic [2:0] {
        ACC_IDLE,
        ACC_PROCESS,
        ACC_UPDATE_LO,
        ACC_UPDATE_HI,
        ACC_WRITEBACK
    } access_state_e;

endpackage

`default_nettype wire

// File: hw/csr_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Head of the MMIO read queue
interface mmio_req_if #(
    parameter int IDX_W = 4,
    parameter int TID_W = 9
);
    logic req_valid;
    logic [IDX_W-1:0] req_idx;
    logic [TID_W-1:0] req_tid;
    // One-cycle pop of the head
    logic deq;

    modport source (output req_valid, req_idx, req_tid, input deq);
    modport sink (input req_valid, req_idx, req_tid, output deq);
endinterface

// Periodic hand-off of the accumulated statistics
interface stat_upd_if #(
    parameter int IDX_VEC_W = 24,
    parameter int CNT_VEC_W = 96
);
    logic upd_en;
    logic [IDX_VEC_W-1:0] idx_vec;
    logic [CNT_VEC_W-1:0] cnt_vec;
    logic upd_rdy;

    modport source (output upd_en, idx_vec, cnt_vec, input upd_rdy);
    modport sink (input upd_en, idx_vec, cnt_vec, output upd_rdy);
endinterface

// 64-bit access port of the CSR store
interface csr_mem_if #(
    parameter int IDX_W = 4,
    parameter int DATA_W = 64
);
    logic rd_en;
    logic [IDX_W-1:0] rd_idx;
    logic rd_rdy;
    logic [DATA_W-1:0] rd_val;
    logic rd_val_valid;

    logic wr_en;
    logic [IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0] wr_val;
    logic wr_rdy;

    modport master (output rd_en, rd_idx, wr_en, wr_idx, wr_val,
                    input rd_rdy, rd_val, rd_val_valid, wr_rdy);
    modport slave (input rd_en, rd_idx, wr_en, wr_idx, wr_val,
                   output rd_rdy, rd_val, rd_val_valid, wr_rdy);
endinterface

`default_nettype wire

// File: hw/mmio_read_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module mmio_read_queue (
    input  logic clk,
    input  logic reset,
    input  logic mmio_rd_valid,
    input  csr_pkg::mmio_addr_t mmio_rd_addr,
    input  csr_pkg::tid_t mmio_rd_tid,
    mmio_req_if.source q
);

    localparam int PTR_W = $clog2(`REQ_FIFO_DEPTH);

    // Incoming read, registered for timing
    logic in_valid;
    csr_pkg::mmio_addr_t in_addr;
    csr_pkg::tid_t in_tid;

    always_ff @(posedge clk)
    begin
        if (reset)
            in_valid <= 1'b0;
        else
            in_valid <= mmio_rd_valid;
        in_addr <= mmio_rd_addr;
        in_tid <= mmio_rd_tid;
    end

    // Dword offset inside the window
    csr_pkg::mmio_addr_t offset;
    logic enq;

    assign offset = in_addr - `CSR_BASE_ADDR;
    // Reads outside the window are dropped here
    assign enq = in_valid && (in_addr >= `CSR_BASE_ADDR) &&
                 (32'(in_addr) < 32'(`CSR_BASE_ADDR) + `CSR_WINDOW_DWORDS);

    // ====================
    // Request FIFO
    // ====================

    csr_pkg::csr_idx_t fifo_idx [`REQ_FIFO_DEPTH];
    csr_pkg::tid_t fifo_tid [`REQ_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;

    always_ff @(posedge clk)
    begin
        // Dword offset to 64-bit entry index
        if (enq)
        begin
            fifo_idx[wr_ptr] <= csr_pkg::csr_idx_t'(offset >> 1);
            fifo_tid[wr_ptr] <= in_tid;
        end

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + PTR_W'(enq);
            rd_ptr <= rd_ptr + PTR_W'(q.deq);
            count <= count + (PTR_W+1)'(enq) - (PTR_W+1)'(q.deq);
        end
    end

    assign q.req_valid = (count != '0);
    assign q.req_idx = fifo_idx[rd_ptr];
    assign q.req_tid = fifo_tid[rd_ptr];

    // Host keeps no more reads in flight than the queue holds
    assert property (@(posedge clk) disable iff (reset)
        enq |-> (count < (PTR_W+1)'(`REQ_FIFO_DEPTH)));

endmodule

`default_nettype wire

// File: hw/stat_accumulators.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module stat_accumulators (
    input  logic clk,
    input  logic reset,
    input  logic [`CSR_NUM_STATS-1:0] stat_events,
    stat_upd_if.source upd
);

    // ====================
    // Flush timer
    // ====================

    // Saturates at the flush point until the fold FSM takes the counts
    logic [`STAT_FLUSH_PERIOD_LOG2:0] timer;
    logic flush;

    always_ff @(posedge clk)
    begin
        if (reset || flush)
            timer <= '0;
        else if (!timer[`STAT_FLUSH_PERIOD_LOG2])
            timer <= timer + 1'b1;

        // Ready is sampled a cycle ahead, never two pulses in a row
        if (reset)
            flush <= 1'b0;
        else
            flush <= timer[`STAT_FLUSH_PERIOD_LOG2] && upd.upd_rdy && !flush;
    end

    // ====================
    // Event accumulators
    // ====================

    logic [`CSR_NUM_STATS-1:0] ev_q;
    csr_pkg::stat_cnt_vec_t acc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ev_q <= '0;
            acc <= '0;
        end
        else
        begin
            ev_q <= stat_events;
            // Cleared on flush, but an event of that cycle is kept
            for (int i = 0; i < `CSR_NUM_STATS; i++)
            begin
                acc[i] <= (flush ? '0 : acc[i]) + csr_pkg::stat_cnt_t'(ev_q[i]);
            end
        end
    end

    assign upd.upd_en = flush;
    assign upd.cnt_vec = acc;
    // Fixed store entries, statistic 0 in the low bits
    assign upd.idx_vec = {`CSR_STAT5_IDX, `CSR_STAT4_IDX, `CSR_STAT3_IDX,
                          `CSR_STAT2_IDX, `CSR_STAT1_IDX, `CSR_STAT0_IDX};

endmodule

`default_nettype wire

// File: hw/csr_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_store (
    input  logic clk,
    input  logic reset,
    csr_mem_if.slave mem
);

    localparam int WORDS = 2 * `CSR_NUM_ENTRIES;

    // Two 32-bit words per entry, low half at the even address
    logic [31:0] words [WORDS];

    logic initialized;
    csr_pkg::csr_idx_t init_idx;

    // Startup contents of each entry
    function automatic csr_pkg::csr_word_t init_value(input csr_pkg::csr_idx_t idx);
        case (idx)
            `CSR_F0_DFH_IDX: init_value = `CSR_F0_DFH_VAL;
            `CSR_F0_ID_L_IDX: init_value = `CSR_F0_ID_L_VAL;
            `CSR_F0_ID_H_IDX: init_value = `CSR_F0_ID_H_VAL;
            `CSR_F1_DFH_IDX: init_value = `CSR_F1_DFH_VAL;
            `CSR_F1_ID_L_IDX: init_value = `CSR_F1_ID_L_VAL;
            `CSR_F1_ID_H_IDX: init_value = `CSR_F1_ID_H_VAL;
            default: init_value = '0;
        endcase
    endfunction

    // ====================
    // Write path
    // ====================

    logic wr_en_q;
    csr_pkg::csr_idx_t wr_idx_q;
    csr_pkg::csr_word_t wr_val_q;
    // Which half goes out this cycle
    logic wr_half;
    logic wen;
    csr_pkg::csr_idx_t waddr;
    csr_pkg::csr_word_t wfull;
    logic [31:0] wdata;

    // Loader writes every cycle, otherwise low then high half of a write
    assign wen = !initialized || wr_en_q || wr_half;
    assign waddr = initialized ? wr_idx_q : init_idx;
    assign wfull = initialized ? wr_val_q : init_value(init_idx);
    assign wdata = wr_half ? wfull[63:32] : wfull[31:0];
    assign mem.wr_rdy = initialized && !wr_en_q && !wr_half;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_en_q <= 1'b0;
            wr_half <= 1'b0;
            initialized <= 1'b0;
            init_idx <= '0;
        end
        else
        begin
            // Writes are delayed one cycle
            wr_en_q <= mem.wr_en;
            wr_half <= wr_half ^ wen;
            if (!initialized && wr_half)
            begin
                init_idx <= init_idx + 1'b1;
                initialized <= (init_idx == csr_pkg::csr_idx_t'(`CSR_NUM_ENTRIES - 1));
            end
        end

        if (mem.wr_en)
        begin
            wr_idx_q <= mem.wr_idx;
            wr_val_q <= mem.wr_val;
        end
    end

    // ====================
    // Read path
    // ====================

    logic rd_half;
    logic rd_busy;
    logic [2:0] rd_pipe;
    csr_pkg::csr_idx_t rd_idx_q;
    csr_pkg::csr_idx_t raddr;
    logic [31:0] ram_q;
    logic [31:0] rdata;
    logic [31:0] rd_val_low;

    // Reads also wait for a write to drain, so no torn values
    assign mem.rd_rdy = initialized && !rd_busy && !wr_en_q && !wr_half;
    assign raddr = rd_half ? rd_idx_q : mem.rd_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_half <= 1'b0;
            rd_busy <= 1'b0;
            rd_pipe <= '0;
        end
        else
        begin
            // High half fetched the cycle after the low half
            rd_half <= mem.rd_en;
            rd_pipe <= {rd_pipe[1:0], mem.rd_en};
            if (mem.rd_en)
                rd_busy <= 1'b1;
            else if (rd_pipe[2])
                rd_busy <= 1'b0;
        end

        if (mem.rd_en)
            rd_idx_q <= mem.rd_idx;

        if (wen)
            words[{waddr, wr_half}] <= wdata;
        // RAM read register, then output register
        ram_q <= words[{raddr, rd_half}];
        rdata <= ram_q;
        if (rd_pipe[1])
            rd_val_low <= rdata;
    end

    // Joined value, 3 cycles after rd_en
    assign mem.rd_val = {rdata, rd_val_low};
    assign mem.rd_val_valid = rd_pipe[2];

    assert property (@(posedge clk) disable iff (reset)
        mem.rd_en |-> (initialized && !rd_busy));

endmodule

`default_nettype wire

// File: hw/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_access (
    input  logic clk,
    input  logic reset,
    mmio_req_if.sink q,
    stat_upd_if.sink upd,
    // Master side of the store port, shared with the store below
    csr_mem_if mem,
    output logic rsp_valid,
    output csr_pkg::tid_t rsp_tid,
    output csr_pkg::csr_word_t rsp_data
);

    csr_store store (.clk, .reset, .mem(mem));

    csr_pkg::access_state_e state;
    logic stat_active;
    logic stat_rd;

    // ====================
    // Host reads
    // ====================

    logic rd_active;
    logic rd_start;
    csr_pkg::tid_t tid_q;

    // Host first, but never while a fold owns the store
    assign rd_start = q.req_valid && !rd_active && mem.rd_rdy && !stat_active;
    assign q.deq = rd_start;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_active <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= rd_active && mem.rd_val_valid;
            if (rd_start)
                rd_active <= 1'b1;
            else if (mem.rd_val_valid)
                rd_active <= 1'b0;
        end

        if (rd_start)
            tid_q <= q.req_tid;
        if (rd_active && mem.rd_val_valid)
        begin
            rsp_tid <= tid_q;
            rsp_data <= mem.rd_val;
        end
    end

    // ====================
    // Statistics fold
    // ====================

    csr_pkg::stat_idx_vec_t idx_q;
    csr_pkg::stat_cnt_vec_t cnt_q;
    logic [2:0] stat_num;
    logic carry;
    logic [31:0] hi_q;
    csr_pkg::csr_word_t wr_val_q;

    assign stat_active = (state == csr_pkg::ACC_UPDATE_LO) ||
                         (state == csr_pkg::ACC_UPDATE_HI) ||
                         (state == csr_pkg::ACC_WRITEBACK);
    assign stat_rd = (state == csr_pkg::ACC_PROCESS) && mem.rd_rdy && !q.req_valid;
    assign upd.upd_rdy = (state == csr_pkg::ACC_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= csr_pkg::ACC_IDLE;
            stat_num <= '0;
        end
        else
        begin
            case (state)
                csr_pkg::ACC_IDLE:
                begin
                    if (upd.upd_en)
                    begin
                        state <= csr_pkg::ACC_PROCESS;
                        stat_num <= '0;
                        idx_q <= upd.idx_vec;
                        cnt_q <= upd.cnt_vec;
                    end
                end
                csr_pkg::ACC_PROCESS:
                begin
                    if (stat_rd)
                        state <= csr_pkg::ACC_UPDATE_LO;
                end
                csr_pkg::ACC_UPDATE_LO:
                begin
                    // Low half plus count, keep the carry for the high half
                    if (mem.rd_val_valid)
                    begin
                        state <= csr_pkg::ACC_UPDATE_HI;
                        {carry, wr_val_q[31:0]} <= {1'b0, mem.rd_val[31:0]} + 33'(cnt_q[0]);
                        hi_q <= mem.rd_val[63:32];
                    end
                end
                csr_pkg::ACC_UPDATE_HI:
                begin
                    state <= csr_pkg::ACC_WRITEBACK;
                    wr_val_q[63:32] <= hi_q + 32'(carry);
                end
                csr_pkg::ACC_WRITEBACK:
                begin
                    if (mem.wr_rdy)
                    begin
                        // Next statistic moves into slot 0
                        idx_q <= idx_q >> $bits(csr_pkg::csr_idx_t);
                        cnt_q <= cnt_q >> $bits(csr_pkg::stat_cnt_t);
                        stat_num <= stat_num + 1'b1;
                        if (stat_num == 3'(`CSR_NUM_STATS - 1))
                            state <= csr_pkg::ACC_IDLE;
                        else
                            state <= csr_pkg::ACC_PROCESS;
                    end
                end
                default:
                    state <= csr_pkg::ACC_IDLE;
            endcase
        end
    end

    // Store port mux
    assign mem.rd_en = rd_start || stat_rd;
    assign mem.rd_idx = rd_start ? q.req_idx : idx_q[0];
    assign mem.wr_en = (state == csr_pkg::ACC_WRITEBACK) && mem.wr_rdy;
    assign mem.wr_idx = idx_q[0];
    assign mem.wr_val = wr_val_q;

    // No write-back while a host read is still in flight
    assert property (@(posedge clk) disable iff (reset) mem.wr_en |-> !rd_active);
    // Each returned value belongs to exactly one waiting read, host or fold
    assert property (@(posedge clk) disable iff (reset)
        mem.rd_val_valid |-> (rd_active != (state == csr_pkg::ACC_UPDATE_LO)));

endmodule

`default_nettype wire

// File: hw/csr_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_manager (
    input  logic clk,
    input  logic reset,
    input  logic mmio_rd_valid,
    input  csr_pkg::mmio_addr_t mmio_rd_addr,
    input  csr_pkg::tid_t mmio_rd_tid,
    input  logic [`CSR_NUM_STATS-1:0] stat_events,
    output logic rsp_valid,
    output csr_pkg::tid_t rsp_tid,
    output csr_pkg::csr_word_t rsp_data
);

    mmio_req_if #(
        .IDX_W($bits(csr_pkg::csr_idx_t)),
        .TID_W($bits(csr_pkg::tid_t))
    ) req_bus ();

    stat_upd_if #(
        .IDX_VEC_W($bits(csr_pkg::stat_idx_vec_t)),
        .CNT_VEC_W($bits(csr_pkg::stat_cnt_vec_t))
    ) upd_bus ();

    csr_mem_if #(
        .IDX_W($bits(csr_pkg::csr_idx_t)),
        .DATA_W($bits(csr_pkg::csr_word_t))
    ) mem_bus ();

    // Host reads in, range checked and queued
    mmio_read_queue read_queue (
        .clk,
        .reset,
        .mmio_rd_valid,
        .mmio_rd_addr,
        .mmio_rd_tid,
        .q(req_bus)
    );

    stat_accumulators stats (.clk, .reset, .stat_events, .upd(upd_bus));

    // Owns the store and builds the responses
    csr_access access (
        .clk,
        .reset,
        .q(req_bus),
        .upd(upd_bus),
        .mem(mem_bus),
        .rsp_valid,
        .rsp_tid,
        .rsp_data
    );

endmodule

`default_nettype wire

// File: tb/tb_csr_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module tb_csr_manager;

    localparam int CLK_PERIOD = 10;
    // Two flush periods plus slack, after the last event
    localparam int SETTLE_CYCLES = 2 * (1 << `STAT_FLUSH_PERIOD_LOG2) + 200;
    localparam int MIX_READS = 200;
    localparam int STAT_CYCLES = 3000;
    localparam int BURST_CYCLES = 2100;
    localparam int DRAIN_LIMIT = 1000;

    // Cycle budget of each test
    localparam int LEN_HEADER = 300;
    localparam int LEN_UNUSED = 300;
    localparam int LEN_MIX = 8 * MIX_READS + DRAIN_LIMIT;
    localparam int LEN_STATS = STAT_CYCLES + SETTLE_CYCLES + DRAIN_LIMIT;
    localparam int LEN_BURST = BURST_CYCLES + SETTLE_CYCLES + 2 * DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = LEN_HEADER + LEN_UNUSED + LEN_MIX + LEN_STATS +
                                     LEN_BURST + 2000;

    logic clk;
    logic reset;
    logic mmio_rd_valid;
    csr_pkg::mmio_addr_t mmio_rd_addr;
    csr_pkg::tid_t mmio_rd_tid;
    logic [`CSR_NUM_STATS-1:0] stat_events;
    logic rsp_valid;
    csr_pkg::tid_t rsp_tid;
    csr_pkg::csr_word_t rsp_data;

    csr_manager dut (
        .clk,
        .reset,
        .mmio_rd_valid,
        .mmio_rd_addr,
        .mmio_rd_tid,
        .stat_events,
        .rsp_valid,
        .rsp_tid,
        .rsp_data
    );

    // ====================
    // Reference model
    // ====================

    // Expected store contents and event totals per statistic
    csr_pkg::csr_word_t exp_mem [`CSR_NUM_ENTRIES];
    csr_pkg::csr_idx_t stat_idx [`CSR_NUM_STATS];
    logic [63:0] stat_count [`CSR_NUM_STATS];
    // Responses still owed, in request order
    csr_pkg::tid_t exp_tid [$];
    csr_pkg::csr_word_t exp_val [$];

    integer seed;
    int errors;
    int tests_run;
    int tests_failed;
    int errors_at_start;
    string cur_test;
    csr_pkg::tid_t next_tid;
    logic events_done;

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic in_window(input csr_pkg::mmio_addr_t addr);
        return (addr >= `CSR_BASE_ADDR) &&
               (addr < `CSR_BASE_ADDR + 16'(2 * `CSR_NUM_ENTRIES));
    endfunction

    function automatic logic is_stat_entry(input csr_pkg::csr_idx_t idx);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `CSR_NUM_STATS; i++)
        begin
            if (stat_idx[i] == idx)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // One read strobe; in-window reads expect the model value of the entry
    task automatic issue_read(input csr_pkg::mmio_addr_t addr);
        csr_pkg::csr_idx_t idx;
        @(posedge clk);
        mmio_rd_valid <= 1'b1;
        mmio_rd_addr <= addr;
        mmio_rd_tid <= next_tid;
        if (in_window(addr))
        begin
            // Two dwords per 64-bit entry
            idx = csr_pkg::csr_idx_t'((addr - `CSR_BASE_ADDR) >> 1);
            exp_tid.push_back(next_tid);
            exp_val.push_back(exp_mem[idx]);
        end
        next_tid = next_tid + csr_pkg::tid_t'(1);
    endtask

    task automatic read_entry(input csr_pkg::csr_idx_t idx, input logic odd);
        issue_read(`CSR_BASE_ADDR + {11'b0, idx, odd});
    endtask

    task automatic end_reads;
        @(posedge clk);
        mmio_rd_valid <= 1'b0;
    endtask

    // Waits for every owed response, then a quiet stretch for stray ones
    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (exp_tid.size() != 0 && cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (exp_tid.size() != 0)
        begin
            $display("%s: %0d responses never arrived", cur_test, exp_tid.size());
            errors++;
            exp_tid.delete();
            exp_val.delete();
        end
        repeat (20) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test;
        if (errors == errors_at_start)
            $display("test %s: ok", cur_test);
        else
        begin
            $display("test %s: %0d errors", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // Random pulses, about one in four cycles per line
    task automatic drive_events(input int cycles);
        logic [31:0] r;
        logic [`CSR_NUM_STATS-1:0] ev;
        for (int c = 0; c < cycles; c++)
        begin
            @(posedge clk);
            r = $random(seed);
            ev = r[5:0] & r[11:6];
            stat_events <= ev;
            for (int i = 0; i < `CSR_NUM_STATS; i++)
            begin
                if (ev[i])
                    stat_count[i] = stat_count[i] + 64'd1;
            end
        end
        @(posedge clk);
        stat_events <= '0;
    endtask

    task automatic update_stat_model;
        for (int i = 0; i < `CSR_NUM_STATS; i++)
            exp_mem[stat_idx[i]] = stat_count[i];
    endtask

    // Back-to-back reads of entries that a fold never touches
    task automatic read_burst;
        logic [31:0] r;
        int len;
        csr_pkg::csr_idx_t idx;
        r = $random(seed);
        len = 1 + int'(r[15:0]) % 40;
        for (int n = 0; n < len; n++)
        begin
            r = $random(seed);
            idx = r[3:0];
            while (is_stat_entry(idx))
                idx = idx + csr_pkg::csr_idx_t'(1);
            read_entry(idx, r[4]);
        end
        end_reads();
        wait_drain();
        r = $random(seed);
        repeat (r[3:0]) @(posedge clk);
    endtask

    // Response checker, outputs are registered in the DUT
    always @(posedge clk)
    begin
        if (!reset && rsp_valid)
        begin
            if (exp_tid.size() == 0)
            begin
                $display("%s: unexpected rsp_valid with tid %0d", cur_test, rsp_tid);
                errors++;
            end
            else
            begin
                compare_value({cur_test, " tid"}, 64'(exp_tid.pop_front()), 64'(rsp_tid));
                compare_value({cur_test, " data"}, exp_val.pop_front(), rsp_data);
            end
        end
    end

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        logic [31:0] r;
        csr_pkg::mmio_addr_t addr;
        csr_pkg::csr_idx_t hdr_idx [6];

        seed = 22;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        next_tid = '0;
        events_done = 1'b0;
        foreach (exp_mem[i])
            exp_mem[i] = '0;
        exp_mem[`CSR_F0_DFH_IDX] = `CSR_F0_DFH_VAL;
        exp_mem[`CSR_F0_ID_L_IDX] = `CSR_F0_ID_L_VAL;
        exp_mem[`CSR_F0_ID_H_IDX] = `CSR_F0_ID_H_VAL;
        exp_mem[`CSR_F1_DFH_IDX] = `CSR_F1_DFH_VAL;
        exp_mem[`CSR_F1_ID_L_IDX] = `CSR_F1_ID_L_VAL;
        exp_mem[`CSR_F1_ID_H_IDX] = `CSR_F1_ID_H_VAL;
        hdr_idx = '{`CSR_F0_DFH_IDX, `CSR_F0_ID_L_IDX, `CSR_F0_ID_H_IDX,
                    `CSR_F1_DFH_IDX, `CSR_F1_ID_L_IDX, `CSR_F1_ID_H_IDX};
        stat_idx = '{`CSR_STAT0_IDX, `CSR_STAT1_IDX, `CSR_STAT2_IDX,
                     `CSR_STAT3_IDX, `CSR_STAT4_IDX, `CSR_STAT5_IDX};
        foreach (stat_count[i])
            stat_count[i] = '0;

        reset <= 1'b1;
        mmio_rd_valid <= 1'b0;
        mmio_rd_addr <= '0;
        mmio_rd_tid <= '0;
        stat_events <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Issued while the loader still runs, so they wait in the queue
        start_test("header_table");
        foreach (hdr_idx[i])
        begin
            read_entry(hdr_idx[i], 1'b0);
            read_entry(hdr_idx[i], 1'b1);
        end
        end_reads();
        wait_drain();
        finish_test();

        start_test("unused_entries");
        for (int i = 0; i < `CSR_NUM_ENTRIES; i++)
        begin
            if (exp_mem[i] == '0)
                read_entry(csr_pkg::csr_idx_t'(i), 1'b0);
        end
        end_reads();
        wait_drain();
        finish_test();

        // Window edges first, then a random mix
        start_test("window_mix");
        issue_read(`CSR_BASE_ADDR - 16'd1);
        issue_read(`CSR_BASE_ADDR);
        issue_read(`CSR_BASE_ADDR + 16'(2 * `CSR_NUM_ENTRIES - 1));
        issue_read(`CSR_BASE_ADDR + 16'(2 * `CSR_NUM_ENTRIES));
        issue_read(16'h0000);
        issue_read(16'hffff);
        for (int n = 0; n < MIX_READS; n++)
        begin
            r = $random(seed);
            if (r[16])
                addr = `CSR_BASE_ADDR + {11'b0, r[4:0]};
            else
                addr = r[15:0];
            issue_read(addr);
            // Keeps the queue well below its depth
            if (exp_tid.size() >= 16 || r[18:17] == 2'b00)
                end_reads();
            while (exp_tid.size() >= 16)
                @(posedge clk);
        end
        end_reads();
        wait_drain();
        finish_test();

        start_test("statistics");
        drive_events(STAT_CYCLES);
        repeat (SETTLE_CYCLES) @(posedge clk);
        update_stat_model();
        for (int i = 0; i < `CSR_NUM_STATS; i++)
            read_entry(stat_idx[i], 1'b0);
        end_reads();
        wait_drain();
        finish_test();

        // Bursts keep coming while the folds run
        start_test("reads_during_stats");
        fork
            begin
                drive_events(BURST_CYCLES);
                events_done = 1'b1;
            end
            begin
                while (!events_done)
                    read_burst();
            end
        join
        repeat (SETTLE_CYCLES) @(posedge clk);
        update_stat_model();
        for (int i = 0; i < `CSR_NUM_ENTRIES; i++)
            read_entry(csr_pkg::csr_idx_t'(i), 1'b1);
        end_reads();
        wait_drain();
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog sized from the test budgets
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_ifs.sv
hw/mmio_read_queue.sv
hw/stat_accumulators.sv
hw/csr_store.sv
hw/csr_access.sv
hw/csr_manager.sv
tb/tb_csr_manager.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR manager testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_csr_manager -o sim_csr_manager
./obj_dir/sim_csr_manager > sim.log 2>&1
cat sim.log

if grep -F -q '** FAIL **' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
